// File: Makefile
TOP := fpga2cpu_dma_tb

all: run

build:
	verilator --binary --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o sim_$(TOP)

run: build
	./obj_dir/sim_$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Test failed" sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi

lint:
	verilator --lint-only -Wall -f vlog.f --top-module fpga2cpu_dma

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: sim/fpga2cpu_dma_tb.sv
`include "dma_settings.svh"

module fpga2cpu_dma_tb
    import dma_pkg::*;
();

    localparam logic [63:0] PKT_BASE = 64'h0000_0001_0000_0000;
    localparam logic [63:0] DSC_BASE = 64'h0000_0002_0000_0000;

    logic                        clk = 1'b0;
    logic                        reset;
    flit_t                       pkt_wr_data;
    pkt_desc_t                   dsc_wr_data;
    logic                        pkt_wr_en, dsc_wr_en, tail_wr_en, bas_write;
    logic                        bas_waitrequest = 1'b0;
    logic [`DMA_FIFO_AWIDTH-1:0] pkt_occup, dsc_occup;
    logic [`DMA_RB_AWIDTH-1:0]   pkt_head, dsc_head, pkt_rb_size, dsc_rb_size;
    logic [`DMA_RB_AWIDTH-1:0]   out_pkt_tail, out_dsc_tail;
    logic [63:0]                 pkt_buf_addr, dsc_buf_addr, bas_address, bas_byteenable;
    bas_word_u                   bas_writedata;
    logic [3:0]                  bas_burstcount;
    logic [31:0]                 dma_stall_cnt, ring_full_cnt;

    // expected beats in bus order, and the beats the slave accepted
    logic [63:0]                 exp_addr [$];
    logic [`DMA_FLIT_BITS-1:0]   exp_data [$];
    logic                        exp_is_cpl [$];
    logic [31:0]                 exp_tails [$];
    logic [63:0]                 got_addr [$];
    logic [`DMA_FLIT_BITS-1:0]   got_data [$];

    logic                        rand_wait = 1'b0;
    logic                        consume = 1'b1;
    logic                        cpl_accepted = 1'b0;
    logic [`DMA_RB_AWIDTH-1:0]   model_pkt_tail, model_dsc_tail;
    logic [63:0]                 burst_addr, g_addr, e_addr;
    logic [31:0]                 e_tails;
    bas_word_u                   g_word, e_word;
    int                          burst_left, beat_cnt, errors, test_errors;
    int                          tests_run, tests_failed, beats_before, cycles;
    string                       test_name;

    fpga2cpu_dma dut_i (.*);

    always #50 clk = ~clk;

    function automatic logic [63:0] slot_address(input logic [63:0] base, input int slot);
        return base + 64'(slot) * 64;
    endfunction

    function automatic logic [`DMA_RB_AWIDTH-1:0] next_slot(input int slot, input int size);
        return (slot + 1 == size) ? '0 : `DMA_RB_AWIDTH'(slot + 1);
    endfunction

    // completion record with signal set, the new packet tail, the queue id and zero pad
    function automatic logic [`DMA_FLIT_BITS-1:0] completion_word(input int tail, input int qid);
        bas_word_u w;
        w.raw = '0;
        w.cpl.signal = 1'b1;
        w.cpl.tail = 64'(tail);
        w.cpl.queue_id = `DMA_QUEUE_BITS'(qid);
        return w.raw;
    endfunction

    function automatic logic [`DMA_FLIT_BITS-1:0] random_data();
        logic [`DMA_FLIT_BITS-1:0] r;
        for (int i = 0; i < `DMA_FLIT_BITS / 32; i++) begin
            r[i*32 +: 32] = $urandom;
        end
        return r;
    endfunction

    // bus slave with random waitrequest that rebuilds beat addresses per burst
    always @(posedge clk) begin
        if (reset) begin
            bas_waitrequest <= 1'b0;
            burst_left = 0;
        end else begin
            bas_waitrequest <= rand_wait && ($urandom_range(0, 3) == 0);
            if (bas_write && !bas_waitrequest) begin
                if (burst_left <= 0) begin
                    assert (bas_burstcount >= 1 && bas_burstcount <= `DMA_MAX_BURST) else begin
                        $display("error bas_burstcount: got %h expected 1 to 8", bas_burstcount);
                        errors++;
                    end
                    burst_addr = bas_address;
                    burst_left = bas_burstcount;
                end
                assert (bas_byteenable == {64{1'b1}}) else begin
                    $display("error bas_byteenable: got %h expected %h",
                             bas_byteenable, {64{1'b1}});
                    errors++;
                end
                got_addr.push_back(burst_addr);
                got_data.push_back(bas_writedata);
                burst_addr += 64;
                burst_left--;
                beat_cnt++;
            end
        end
    end

    // compare every logged beat against the reference
    always @(negedge clk) begin
        while (got_addr.size() != 0) begin
            g_addr = got_addr.pop_front();
            g_word = got_data.pop_front();
            assert (exp_addr.size() != 0) else begin
                $display("bus write at address %h when no write was expected", g_addr);
                errors++;
            end
            if (exp_addr.size() != 0) begin
                e_addr = exp_addr.pop_front();
                e_word = exp_data.pop_front();
                assert (g_addr == e_addr) else begin
                    $display("error bas_address: got %h expected %h", g_addr, e_addr);
                    errors++;
                end
                if (exp_is_cpl.pop_front()) begin
                    assert (g_word.cpl.signal == 1'b1) else begin
                        $display("error bas_writedata.cpl.signal: got %h expected 1",
                                 g_word.cpl.signal);
                        errors++;
                    end
                    assert (g_word.cpl.pad == '0) else begin
                        $display("error bas_writedata.cpl.pad: got %h expected 0",
                                 g_word.cpl.pad);
                        errors++;
                    end
                    assert (g_word.cpl.tail == e_word.cpl.tail) else begin
                        $display("error bas_writedata.cpl.tail: got %h expected %h",
                                 g_word.cpl.tail, e_word.cpl.tail);
                        errors++;
                    end
                    assert (g_word.cpl.queue_id == e_word.cpl.queue_id) else begin
                        $display("error bas_writedata.cpl.queue_id: got %h expected %h",
                                 g_word.cpl.queue_id, e_word.cpl.queue_id);
                        errors++;
                    end
                end else begin
                    assert (g_word.raw == e_word.raw) else begin
                        $display("error bas_writedata: got %h expected %h", g_word.raw, e_word.raw);
                        errors++;
                    end
                end
            end
        end
    end

    // tail strobe check where the CPU side consumes everything when enabled
    always @(posedge clk) begin
        if (!reset && tail_wr_en) begin
            assert (cpl_accepted) else begin
                $display("tail_wr_en did not come one cycle after the completion write");
                errors++;
            end
            assert (exp_tails.size() != 0) else begin
                $display("tail_wr_en pulsed with no packet outstanding");
                errors++;
            end
            if (exp_tails.size() != 0) begin
                e_tails = exp_tails.pop_front();
                assert (out_pkt_tail == e_tails[31:16]) else begin
                    $display("error out_pkt_tail: got %h expected %h", out_pkt_tail, e_tails[31:16]);
                    errors++;
                end
                assert (out_dsc_tail == e_tails[15:0]) else begin
                    $display("error out_dsc_tail: got %h expected %h", out_dsc_tail, e_tails[15:0]);
                    errors++;
                end
            end
            if (consume) begin
                pkt_head <= out_pkt_tail;
                dsc_head <= out_dsc_tail;
            end
        end
        // a completion beat accepted at this edge makes the strobe due at the next one
        cpl_accepted = !reset && bas_write && !bas_waitrequest && bas_address >= DSC_BASE;
    end

    task automatic start_test(input string name, input int pkt_size, input int dsc_size,
                              input logic rand_w, input logic cons);
        test_name = name;
        test_errors = errors;
        tests_run++;
        reset <= 1'b1;
        rand_wait <= rand_w;
        consume <= cons;
        pkt_rb_size <= `DMA_RB_AWIDTH'(pkt_size);
        dsc_rb_size <= `DMA_RB_AWIDTH'(dsc_size);
        pkt_head <= '0;
        dsc_head <= '0;
        repeat (16) @(posedge clk);
        exp_addr.delete();
        exp_data.delete();
        exp_is_cpl.delete();
        exp_tails.delete();
        got_addr.delete();
        got_data.delete();
        model_pkt_tail = '0;
        model_dsc_tail = '0;
        reset <= 1'b0;
        @(posedge clk);
    endtask

    task automatic send_packet(input int n, input int qid);
        flit_t     f;
        pkt_desc_t d;
        int        waited;
        d.queue_id = `DMA_QUEUE_BITS'(qid);
        d.size = `DMA_SIZE_BITS'(n);
        for (int i = 0; i < n; i++) begin
            waited = 0;
            while (pkt_occup > `DMA_FIFO_DEPTH - 4 && waited < 2000) begin
                @(posedge clk);
                pkt_wr_en <= 1'b0;
                dsc_wr_en <= 1'b0;
                waited++;
            end
            assert (waited < 2000) else begin
                $display("timed out waiting for room in the packet FIFO");
                errors++;
            end
            f.sop = (i == 0);
            f.eop = (i == n - 1);
            f.data = random_data();
            exp_addr.push_back(slot_address(PKT_BASE, model_pkt_tail));
            exp_data.push_back(f.data);
            exp_is_cpl.push_back(1'b0);
            model_pkt_tail = next_slot(model_pkt_tail, pkt_rb_size);
            @(posedge clk);
            pkt_wr_data <= f;
            pkt_wr_en <= 1'b1;
            dsc_wr_data <= d;
            dsc_wr_en <= (i == n - 1);
        end
        @(posedge clk);
        pkt_wr_en <= 1'b0;
        dsc_wr_en <= 1'b0;
        exp_addr.push_back(slot_address(DSC_BASE, model_dsc_tail));
        exp_data.push_back(completion_word(model_pkt_tail, qid));
        exp_is_cpl.push_back(1'b1);
        model_dsc_tail = next_slot(model_dsc_tail, dsc_rb_size);
        exp_tails.push_back({model_pkt_tail, model_dsc_tail});
    endtask

    task automatic wait_all_written();
        cycles = 0;
        while ((exp_addr.size() != 0 || exp_tails.size() != 0) && cycles < 20000) begin
            @(posedge clk);
            cycles++;
        end
        assert (exp_addr.size() == 0 && exp_tails.size() == 0) else begin
            $display("timed out waiting for all packets to be written");
            errors++;
        end
    endtask

    task automatic end_test();
        assert (pkt_occup == 0) else begin
            $display("error pkt_occup: got %h expected 0", pkt_occup);
            errors++;
        end
        assert (dsc_occup == 0) else begin
            $display("error dsc_occup: got %h expected 0", dsc_occup);
            errors++;
        end
        if (errors == test_errors) begin
            $display("test %0d %s: passed", tests_run, test_name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, test_name, errors - test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        void'($urandom(15835));
        reset = 1'b1;
        pkt_wr_data = '0;
        pkt_wr_en = 1'b0;
        dsc_wr_data = '0;
        dsc_wr_en = 1'b0;
        pkt_head = '0;
        dsc_head = '0;
        pkt_buf_addr = PKT_BASE;
        dsc_buf_addr = DSC_BASE;
        pkt_rb_size = 16'd1024;
        dsc_rb_size = 16'd64;

        start_test("consecutive slots", 1024, 64, 1'b0, 1'b1);
        for (int n = 1; n <= 20; n++)
            send_packet(n, n);
        wait_all_written();
        end_test();

        // sizes chosen so that one packet straddles the ring end and one ends on it
        start_test("packet ring wrap", 16, 64, 1'b0, 1'b1);
        send_packet(5, 101);
        send_packet(7, 102);
        send_packet(9, 103);
        send_packet(11, 104);
        send_packet(13, 105);
        wait_all_written();
        end_test();

        start_test("completion records", 64, 4, 1'b0, 1'b1);
        for (int k = 0; k < 6; k++)
            send_packet(4, 300 + k);
        wait_all_written();
        end_test();

        start_test("random waitrequest", 256, 64, 1'b1, 1'b1);
        for (int k = 0; k < 12; k++)
            send_packet($urandom_range(1, 20), 400 + k);
        wait_all_written();
        assert (dma_stall_cnt != 0) else begin
            $display("dma_stall_cnt stayed zero under random waitrequest");
            errors++;
        end
        end_test();

        // head held at 0 so the second packet finds only 3 free slots
        start_test("ring full", 16, 64, 1'b0, 1'b0);
        send_packet(12, 500);
        wait_all_written();
        beats_before = beat_cnt;
        send_packet(6, 501);
        cycles = 0;
        while (ring_full_cnt < 20 && cycles < 1000) begin
            @(posedge clk);
            cycles++;
        end
        assert (ring_full_cnt >= 20) else begin
            $display("ring_full_cnt did not rise while the packet ring lacked room");
            errors++;
        end
        assert (beat_cnt == beats_before) else begin
            $display("bus beats were accepted while the packet ring lacked room");
            errors++;
        end
        pkt_head <= 16'd12;
        wait_all_written();
        end_test();

        $display("tests run %0d, tests with errors %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: source/dma_pkg.sv
`include "dma_settings.svh"

package dma_pkg;

    // one packet flit with its framing flags
    typedef struct packed {
        logic                      sop;
        logic                      eop;
        logic [`DMA_FLIT_BITS-1:0] data;
    } flit_t;

    // one entry per packet, written next to the flits
    typedef struct packed {
        logic [`DMA_QUEUE_BITS-1:0] queue_id;
        logic [`DMA_SIZE_BITS-1:0]  size;
    } pkt_desc_t;

    // completion record as the CPU sees it
    // signal sits in the lowest bits so it lands in byte 0 of the slot
    typedef struct packed {
        logic [`DMA_FLIT_BITS-1-64-`DMA_QUEUE_BITS-1:0] pad;
        logic [`DMA_QUEUE_BITS-1:0]                     queue_id;
        logic [63:0]                                    tail;
        logic                                           signal;
    } cpl_desc_t;

    // a bus data word carries either flit data or a completion record
    typedef union packed {
        logic [`DMA_FLIT_BITS-1:0] raw;
        cpl_desc_t                 cpl;
    } bas_word_u;

endpackage

// File: source/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// one flit is one bus data word
`define DMA_FLIT_BITS 512

// packet and descriptor FIFOs
`define DMA_FIFO_DEPTH 64

// occupancy must be able to count a full FIFO
`define DMA_FIFO_AWIDTH 7

// ring pointers and ring sizes in the CPU memory
`define DMA_RB_AWIDTH 16

// FPGA-side descriptor fields
`define DMA_QUEUE_BITS 12
`define DMA_SIZE_BITS 16

// largest burst on the bus, in flits
`define DMA_MAX_BURST 8

`endif

// File: source/dma_write_engine.sv
`include "dma_settings.svh"

module dma_write_engine
    import dma_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    // packet FIFO head
    input  flit_t                       flit,
    input  logic [`DMA_FIFO_AWIDTH-1:0] pkt_occup,
    output logic                        pkt_rd_en,

    // descriptor FIFO head
    input  pkt_desc_t                   desc,
    input  logic [`DMA_FIFO_AWIDTH-1:0] dsc_occup,
    output logic                        dsc_rd_en,

    // CPU ring state
    input  logic [`DMA_RB_AWIDTH-1:0]   pkt_head,
    input  logic [`DMA_RB_AWIDTH-1:0]   dsc_head,
    input  logic [63:0]                 pkt_buf_addr,
    input  logic [63:0]                 dsc_buf_addr,
    input  logic [`DMA_RB_AWIDTH-1:0]   pkt_rb_size,
    input  logic [`DMA_RB_AWIDTH-1:0]   dsc_rb_size,

    // PCIe burst master, write side
    input  logic                        bas_waitrequest,
    output logic                        bas_write,
    output logic [63:0]                 bas_address,
    output logic [63:0]                 bas_byteenable,
    output bas_word_u                   bas_writedata,
    output logic [3:0]                  bas_burstcount,

    // tail report
    output logic [`DMA_RB_AWIDTH-1:0]   out_pkt_tail,
    output logic [`DMA_RB_AWIDTH-1:0]   out_dsc_tail,
    output logic                        tail_wr_en,

    output logic [31:0]                 dma_stall_cnt,
    output logic [31:0]                 ring_full_cnt
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_BURST_START,
        S_BURST_CONT,
        S_DSC_WRITE
    } state_t;

    state_t                     state;

    logic [`DMA_RB_AWIDTH-1:0]  pkt_tail;
    logic [`DMA_RB_AWIDTH-1:0]  dsc_tail;
    logic [`DMA_RB_AWIDTH-1:0]  pkt_tail_next;
    logic [`DMA_RB_AWIDTH-1:0]  dsc_tail_next;
    logic [`DMA_RB_AWIDTH-1:0]  pkt_free;
    logic [`DMA_RB_AWIDTH-1:0]  dsc_free;
    logic [`DMA_RB_AWIDTH-1:0]  to_ring_end;
    logic [`DMA_RB_AWIDTH-1:0]  burst_len;

    logic [`DMA_SIZE_BITS-1:0]  missing;
    logic [`DMA_SIZE_BITS-1:0]  cur_size;
    logic [`DMA_QUEUE_BITS-1:0] cur_queue;
    logic [3:0]                 beats_left;

    logic                       space_ok;
    logic                       pkt_avail;
    logic                       want_bus;
    logic                       issue_first;
    logic                       issue_next;
    logic                       issue_cpl;
    cpl_desc_t                  cpl_rec;

    function automatic logic [`DMA_RB_AWIDTH-1:0] ring_inc(
        input logic [`DMA_RB_AWIDTH-1:0] ptr,
        input logic [`DMA_RB_AWIDTH-1:0] size
    );
        if (ptr == size - 1'b1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // one slot always stays empty so that full and empty differ
    function automatic logic [`DMA_RB_AWIDTH-1:0] ring_free(
        input logic [`DMA_RB_AWIDTH-1:0] tail,
        input logic [`DMA_RB_AWIDTH-1:0] head,
        input logic [`DMA_RB_AWIDTH-1:0] size
    );
        if (tail >= head) begin
            return size - tail + head - 1'b1;
        end
        return head - tail - 1'b1;
    endfunction

    // every ring slot is one 64-byte line
    function automatic logic [63:0] slot_addr(
        input logic [63:0]                base,
        input logic [`DMA_RB_AWIDTH-1:0] slot
    );
        return base + {{(58 - `DMA_RB_AWIDTH){1'b0}}, slot, 6'b0};
    endfunction

    assign pkt_tail_next = ring_inc(pkt_tail, pkt_rb_size);
    assign dsc_tail_next = ring_inc(dsc_tail, dsc_rb_size);
    assign pkt_free      = ring_free(pkt_tail, pkt_head, pkt_rb_size);
    assign dsc_free      = ring_free(dsc_tail, dsc_head, dsc_rb_size);
    assign to_ring_end   = pkt_rb_size - pkt_tail;

    // the whole remaining packet plus one descriptor must fit
    assign space_ok  = (pkt_free >= `DMA_RB_AWIDTH'(missing)) && (dsc_free != 0);
    assign pkt_avail = (pkt_occup != 0);

    // smallest of missing flits, burst limit and slots before the ring end
    always_comb begin
        burst_len = `DMA_RB_AWIDTH'(`DMA_MAX_BURST);
        if (`DMA_RB_AWIDTH'(missing) < burst_len) begin
            burst_len = `DMA_RB_AWIDTH'(missing);
        end
        if (to_ring_end < burst_len) begin
            burst_len = to_ring_end;
        end
    end

    always_comb begin
        case (state)
            S_BURST_START: want_bus = space_ok && pkt_avail;
            S_BURST_CONT:  want_bus = bas_write || (beats_left != 0 && pkt_avail);
            S_DSC_WRITE:   want_bus = 1'b1;
            default:       want_bus = 1'b0;
        endcase
    end

    assign dsc_rd_en   = (state == S_IDLE) && (dsc_occup != 0) && pkt_avail;
    assign issue_first = (state == S_BURST_START) && !bas_waitrequest && space_ok && pkt_avail;
    assign issue_next  = (state == S_BURST_CONT) && !bas_waitrequest && (beats_left != 0)
                         && pkt_avail;
    assign issue_cpl   = (state == S_DSC_WRITE) && !bas_waitrequest && !bas_write;
    assign pkt_rd_en   = issue_first || issue_next;

    assign bas_byteenable = '1;

    always_comb begin
        cpl_rec          = '0;
        cpl_rec.signal   = 1'b1;
        cpl_rec.tail     = 64'(pkt_tail);
        cpl_rec.queue_id = cur_queue;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= S_IDLE;
            bas_write     <= 1'b0;
            missing       <= '0;
            beats_left    <= '0;
            pkt_tail      <= '0;
            dsc_tail      <= '0;
            out_pkt_tail  <= '0;
            out_dsc_tail  <= '0;
            tail_wr_en    <= 1'b0;
            dma_stall_cnt <= '0;
            ring_full_cnt <= '0;
        end else begin
            tail_wr_en <= 1'b0;

            if (want_bus && bas_waitrequest) begin
                dma_stall_cnt <= dma_stall_cnt + 1'b1;
            end
            if (state == S_BURST_START && !space_ok) begin
                ring_full_cnt <= ring_full_cnt + 1'b1;
            end

            case (state)
                S_IDLE: begin
                    if (dsc_rd_en) begin
                        missing <= desc.size;
                        state   <= S_BURST_START;
                    end
                end
                S_BURST_START: begin
                    if (issue_first) begin
                        bas_write  <= 1'b1;
                        beats_left <= 4'(burst_len - 1'b1);
                        missing    <= missing - 1'b1;
                        pkt_tail   <= pkt_tail_next;
                        state      <= S_BURST_CONT;
                    end
                end
                S_BURST_CONT: begin
                    if (issue_next) begin
                        bas_write  <= 1'b1;
                        beats_left <= beats_left - 1'b1;
                        missing    <= missing - 1'b1;
                        pkt_tail   <= pkt_tail_next;
                    end else if (!bas_waitrequest) begin
                        // beat accepted and nothing to follow it yet
                        bas_write <= 1'b0;
                        if (beats_left == 0) begin
                            state <= (missing == 0) ? S_DSC_WRITE : S_BURST_START;
                        end
                    end
                end
                S_DSC_WRITE: begin
                    if (issue_cpl) begin
                        bas_write <= 1'b1;
                    end else if (!bas_waitrequest) begin
                        // completion record accepted, publish both tails
                        bas_write    <= 1'b0;
                        dsc_tail     <= dsc_tail_next;
                        out_pkt_tail <= pkt_tail;
                        out_dsc_tail <= dsc_tail_next;
                        tail_wr_en   <= 1'b1;
                        state        <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // bus payload and the current packet's descriptor
    always_ff @(posedge clk) begin
        if (dsc_rd_en) begin
            cur_queue <= desc.queue_id;
            cur_size  <= desc.size;
        end
        if (issue_first) begin
            bas_address    <= slot_addr(pkt_buf_addr, pkt_tail);
            bas_burstcount <= 4'(burst_len);
        end
        if (pkt_rd_en) begin
            bas_writedata.raw <= flit.data;
        end
        if (issue_cpl) begin
            bas_address       <= slot_addr(dsc_buf_addr, dsc_tail);
            bas_burstcount    <= 4'd1;
            bas_writedata.cpl <= cpl_rec;
        end
    end

    // FIFO contents must agree with the descriptor size
    a_first_sop: assert property (
        @(posedge clk) disable iff (reset)
        issue_first && (missing == cur_size) |-> flit.sop
    ) else $error("dma_write_engine: first flit without sop");

    a_last_eop: assert property (
        @(posedge clk) disable iff (reset)
        pkt_rd_en && (missing == 1) |-> flit.eop
    ) else $error("dma_write_engine: last flit without eop");

    a_bus_hold: assert property (
        @(posedge clk) disable iff (reset)
        bas_waitrequest |=> $stable(bas_write) && $stable(bas_address)
                            && $stable(bas_writedata) && $stable(bas_burstcount)
    ) else $error("dma_write_engine: bus changed under waitrequest");

    a_burst_range: assert property (
        @(posedge clk) disable iff (reset)
        bas_write |-> (bas_burstcount >= 1) && (bas_burstcount <= `DMA_MAX_BURST)
    ) else $error("dma_write_engine: burst count out of range");

endmodule

// File: source/flit_fifo.sv
`include "dma_settings.svh"

module flit_fifo #(
    parameter int DEPTH  = `DMA_FIFO_DEPTH,
    parameter int DWIDTH = 32
) (
    input  logic                        clk,
    input  logic                        reset,

    input  logic [DWIDTH-1:0]           wr_data,
    input  logic                        wr_en,

    output logic [DWIDTH-1:0]           rd_data,
    input  logic                        rd_en,

    output logic [`DMA_FIFO_AWIDTH-1:0] occup
);

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [DWIDTH-1:0]   mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;

    // pointers wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            occup  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   occup <= occup + 1'b1;
                2'b01:   occup <= occup - 1'b1;
                default: occup <= occup;
            endcase
        end
    end

    // show-ahead so the head entry is visible before the pop
    assign rd_data = mem[rd_ptr];

    a_no_write_full: assert property (
        @(posedge clk) disable iff (reset)
        wr_en |-> occup != DEPTH
    ) else $error("flit_fifo: write while full");

    a_no_read_empty: assert property (
        @(posedge clk) disable iff (reset)
        rd_en |-> occup != 0
    ) else $error("flit_fifo: read while empty");

endmodule

// File: source/fpga2cpu_dma.sv
`include "dma_settings.svh"

module fpga2cpu_dma
    import dma_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,

    // packet input
    input  flit_t                       pkt_wr_data,
    input  logic                        pkt_wr_en,
    output logic [`DMA_FIFO_AWIDTH-1:0] pkt_occup,

    // descriptor input
    input  pkt_desc_t                   dsc_wr_data,
    input  logic                        dsc_wr_en,
    output logic [`DMA_FIFO_AWIDTH-1:0] dsc_occup,

    // CPU ring state
    input  logic [`DMA_RB_AWIDTH-1:0]   pkt_head,
    input  logic [`DMA_RB_AWIDTH-1:0]   dsc_head,
    input  logic [63:0]                 pkt_buf_addr,
    input  logic [63:0]                 dsc_buf_addr,
    input  logic [`DMA_RB_AWIDTH-1:0]   pkt_rb_size,
    input  logic [`DMA_RB_AWIDTH-1:0]   dsc_rb_size,

    // PCIe burst master
    input  logic                        bas_waitrequest,
    output logic                        bas_write,
    output logic [63:0]                 bas_address,
    output logic [63:0]                 bas_byteenable,
    output bas_word_u                   bas_writedata,
    output logic [3:0]                  bas_burstcount,

    output logic [`DMA_RB_AWIDTH-1:0]   out_pkt_tail,
    output logic [`DMA_RB_AWIDTH-1:0]   out_dsc_tail,
    output logic                        tail_wr_en,

    output logic [31:0]                 dma_stall_cnt,
    output logic [31:0]                 ring_full_cnt
);

    flit_t     pkt_rd_data;
    logic      pkt_rd_en;
    pkt_desc_t dsc_rd_data;
    logic      dsc_rd_en;

    flit_fifo #(
        .DEPTH  (`DMA_FIFO_DEPTH),
        .DWIDTH ($bits(flit_t))
    ) pkt_fifo_i (
        .clk     (clk),
        .reset   (reset),
        .wr_data (pkt_wr_data),
        .wr_en   (pkt_wr_en),
        .rd_data (pkt_rd_data),
        .rd_en   (pkt_rd_en),
        .occup   (pkt_occup)
    );

    // one entry per packet, so it never fills before the packet FIFO
    flit_fifo #(
        .DEPTH  (`DMA_FIFO_DEPTH),
        .DWIDTH ($bits(pkt_desc_t))
    ) dsc_fifo_i (
        .clk     (clk),
        .reset   (reset),
        .wr_data (dsc_wr_data),
        .wr_en   (dsc_wr_en),
        .rd_data (dsc_rd_data),
        .rd_en   (dsc_rd_en),
        .occup   (dsc_occup)
    );

    dma_write_engine engine_i (
        .clk             (clk),
        .reset           (reset),
        .flit            (pkt_rd_data),
        .pkt_occup       (pkt_occup),
        .pkt_rd_en       (pkt_rd_en),
        .desc            (dsc_rd_data),
        .dsc_occup       (dsc_occup),
        .dsc_rd_en       (dsc_rd_en),
        .pkt_head        (pkt_head),
        .dsc_head        (dsc_head),
        .pkt_buf_addr    (pkt_buf_addr),
        .dsc_buf_addr    (dsc_buf_addr),
        .pkt_rb_size     (pkt_rb_size),
        .dsc_rb_size     (dsc_rb_size),
        .bas_waitrequest (bas_waitrequest),
        .bas_write       (bas_write),
        .bas_address     (bas_address),
        .bas_byteenable  (bas_byteenable),
        .bas_writedata   (bas_writedata),
        .bas_burstcount  (bas_burstcount),
        .out_pkt_tail    (out_pkt_tail),
        .out_dsc_tail    (out_dsc_tail),
        .tail_wr_en      (tail_wr_en),
        .dma_stall_cnt   (dma_stall_cnt),
        .ring_full_cnt   (ring_full_cnt)
    );

endmodule

// File: vlog.f
+incdir+source
source/dma_pkg.sv
source/flit_fifo.sv
source/dma_write_engine.sv
source/fpga2cpu_dma.sv
sim/fpga2cpu_dma_tb.sv
